// File: Makefile
# Verilator build and run of the execute stage testbench

VERILATOR ?= verilator
TOP       ?= ex_stage_tb
FILELIST  ?= ex_stage.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --timescale 1ns/100ps -j 0

SOURCES := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "no pass line found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: ex_stage.f
source/core_width_pkg.sv
source/alu_op_pkg.sv
source/ex_decode.sv
source/ex_execute.sv
source/ex_result.sv
source/ex_stage.sv
verification/ex_stage_tb.sv

// File: source/alu_op_pkg.sv
//##########################################################################
// alu operation codes and branch codes sent by decode
// one-hot unit enable vector and branch condition select vector
//##########################################################################
package alu_op_pkg;

	localparam int ALU_OP_WIDTH  = 4;
	localparam int BR_OP_WIDTH   = 3;
	localparam int UNIT_NUM      = 10;	// one enable per execution unit
	localparam int BR_COND_WIDTH = 3;

	typedef logic [ALU_OP_WIDTH - 1 : 0]  alu_op_t;	// encoded alu operation
	typedef logic [BR_OP_WIDTH - 1 : 0]   branch_op_t;	// encoded branch type
	typedef logic [UNIT_NUM - 1 : 0]      unit_sel_t;	// one-hot unit enables
	typedef logic [BR_COND_WIDTH - 1 : 0] br_cond_t;	// eq, lt and invert selects

	localparam alu_op_t ALU_NONE = 4'd0;	// no unit active, result 0
	localparam alu_op_t ALU_ADD  = 4'd1;
	localparam alu_op_t ALU_SUB  = 4'd2;
	localparam alu_op_t ALU_SLT  = 4'd3;	// signed set less than
	localparam alu_op_t ALU_SLTU = 4'd4;	// unsigned set less than
	localparam alu_op_t ALU_AND  = 4'd5;
	localparam alu_op_t ALU_OR   = 4'd6;
	localparam alu_op_t ALU_XOR  = 4'd7;
	localparam alu_op_t ALU_SLL  = 4'd8;
	localparam alu_op_t ALU_SRL  = 4'd9;
	localparam alu_op_t ALU_SRA  = 4'd10;	// sign filled right shift

	localparam branch_op_t BR_NONE = 3'd0;	// not a branch
	localparam branch_op_t BR_BEQ  = 3'd1;
	localparam branch_op_t BR_BNE  = 3'd2;
	localparam branch_op_t BR_BLT  = 3'd3;
	localparam branch_op_t BR_BGE  = 3'd4;
	localparam branch_op_t BR_BLTU = 3'd5;
	localparam branch_op_t BR_BGEU = 3'd6;

	localparam int SEL_ADD  = 0;	// bit positions in unit_sel_t
	localparam int SEL_SUB  = 1;
	localparam int SEL_SLT  = 2;
	localparam int SEL_SLTU = 3;
	localparam int SEL_AND  = 4;
	localparam int SEL_OR   = 5;
	localparam int SEL_XOR  = 6;
	localparam int SEL_SLL  = 7;
	localparam int SEL_SRL  = 8;
	localparam int SEL_SRA  = 9;

	localparam int COND_EQ  = 0;	// taken on zero subtract result
	localparam int COND_LT  = 1;	// taken on compare bit
	localparam int COND_INV = 2;	// flips the condition for bne bge bgeu

endpackage

// File: source/core_width_pkg.sv
//##########################################################################
// widths of the rv32 integer datapath
// data word, byte address, shift amount and destination index types
// plus the empty destination marker used by bubbles
//##########################################################################
package core_width_pkg;

	localparam int DATA_WIDTH  = 32;	// xlen of rv32
	localparam int ADDR_WIDTH  = 32;	// byte addressed memory
	localparam int SHAMT_WIDTH = 5;		// log2 of DATA_WIDTH
	localparam int RD_WIDTH    = 6;		// one bit above the 32 register indices

	typedef logic [DATA_WIDTH - 1 : 0]  data_t;	// operand or result word
	typedef logic [ADDR_WIDTH - 1 : 0]  addr_t;	// memory byte address
	typedef logic [SHAMT_WIDTH - 1 : 0] shamt_t;	// low bits of operand 2
	typedef logic [RD_WIDTH - 1 : 0]    rd_t;	// 0..31 name x0..x31

	// index 32 lies outside the register file so later stages never write it
	localparam rd_t RD_NONE = rd_t'(32);

endpackage

// File: source/ex_decode.sv
//##########################################################################
// expands the alu code into one-hot unit enables
// a branch code takes over the compare unit and sets the condition selects
//##########################################################################
`timescale 1ns/100ps

module ex_decode
	import alu_op_pkg::*;
(
	input  alu_op_t    alu_op_i,	// encoded alu operation
	input  branch_op_t branch_op_i,	// encoded branch type
	output unit_sel_t  unit_sel_o,	// one-hot unit enables
	output br_cond_t   br_cond_o	// condition selects for the branch decision
);

	unit_sel_t alu_sel;	// enables from the alu code alone
	unit_sel_t br_sel;	// compare unit needed by the branch
	logic      br_eq;	// beq or bne
	logic      br_lt;	// blt or bge
	logic      br_ltu;	// bltu or bgeu
	logic      br_inv;	// negated form of the condition
	logic      is_branch;

	always_comb
	begin
		alu_sel = '0;
		case (alu_op_i)
			ALU_ADD:  alu_sel[SEL_ADD]  = 1'b1;
			ALU_SUB:  alu_sel[SEL_SUB]  = 1'b1;
			ALU_SLT:  alu_sel[SEL_SLT]  = 1'b1;
			ALU_SLTU: alu_sel[SEL_SLTU] = 1'b1;
			ALU_AND:  alu_sel[SEL_AND]  = 1'b1;
			ALU_OR:   alu_sel[SEL_OR]   = 1'b1;
			ALU_XOR:  alu_sel[SEL_XOR]  = 1'b1;
			ALU_SLL:  alu_sel[SEL_SLL]  = 1'b1;
			ALU_SRL:  alu_sel[SEL_SRL]  = 1'b1;
			ALU_SRA:  alu_sel[SEL_SRA]  = 1'b1;
			default:  alu_sel = '0;	// ALU_NONE and spare codes enable nothing
		endcase
	end

	assign br_eq     = (branch_op_i == BR_BEQ)  | (branch_op_i == BR_BNE);
	assign br_lt     = (branch_op_i == BR_BLT)  | (branch_op_i == BR_BGE);
	assign br_ltu    = (branch_op_i == BR_BLTU) | (branch_op_i == BR_BGEU);
	assign br_inv    = (branch_op_i == BR_BNE) | (branch_op_i == BR_BGE) |
			   (branch_op_i == BR_BGEU);
	assign is_branch = br_eq | br_lt | br_ltu;	// spare branch codes fall back to alu

	// branches reuse the alu compare hardware
	always_comb
	begin
		br_sel           = '0;
		br_sel[SEL_SUB]  = br_eq;	// equality from a zero difference
		br_sel[SEL_SLT]  = br_lt;
		br_sel[SEL_SLTU] = br_ltu;
	end

	assign unit_sel_o = is_branch ? br_sel : alu_sel;	// branch wins over alu code

	always_comb
	begin
		br_cond_o           = '0;
		br_cond_o[COND_EQ]  = br_eq;
		br_cond_o[COND_LT]  = br_lt | br_ltu;	// signedness lives in the unit choice
		br_cond_o[COND_INV] = br_inv;
	end

endmodule

// File: source/ex_execute.sv
//##########################################################################
// execution units with operand gating and an or-combined result
// operand 2 bypass for lui and jumps
// branch decision from the subtract and compare results
//##########################################################################
`timescale 1ns/100ps

module ex_execute
	import core_width_pkg::*;
	import alu_op_pkg::*;
(
	input  data_t     src_data1_i,	// operand 1
	input  data_t     src_data2_i,	// operand 2 or immediate
	input  unit_sel_t unit_sel_i,	// one-hot unit enables
	input  br_cond_t  br_cond_i,	// branch condition selects
	input  logic      only_src2_used_i,	// lui and jumps pass operand 2
	output data_t     alu_result_o,	// result at EX, also forwarded
	output logic      branch_taken_o	// branch condition met
);

	logic  use_adder;	// add and sub share one adder
	data_t adder_src1;
	data_t adder_src2;
	data_t adder_result;
	data_t slt_src1;
	data_t slt_src2;
	logic  slt_bit;		// signed less than
	data_t sltu_src1;
	data_t sltu_src2;
	logic  sltu_bit;	// unsigned less than
	data_t and_result;
	data_t or_result;
	data_t xor_result;
	shamt_t shamt;		// only the low 5 bits of operand 2 count
	data_t sll_src;
	data_t srl_src;
	data_t sra_src;
	logic signed [DATA_WIDTH - 1 : 0] sra_shifted;	// signed so >>> fills with the sign
	data_t alu_result;
	logic  sub_zero;
	logic  cond_true;

	assign use_adder    = unit_sel_i[SEL_ADD] | unit_sel_i[SEL_SUB];
	assign adder_src1   = use_adder ? src_data1_i : '0;
	assign adder_src2   = unit_sel_i[SEL_ADD] ? src_data2_i :
			      (unit_sel_i[SEL_SUB] ? (~src_data2_i + data_t'(1)) : '0);	// two's negate
	assign adder_result = adder_src1 + adder_src2;

	assign slt_src1  = unit_sel_i[SEL_SLT] ? src_data1_i : '0;
	assign slt_src2  = unit_sel_i[SEL_SLT] ? src_data2_i : '0;
	assign slt_bit   = $signed(slt_src1) < $signed(slt_src2);
	assign sltu_src1 = unit_sel_i[SEL_SLTU] ? src_data1_i : '0;
	assign sltu_src2 = unit_sel_i[SEL_SLTU] ? src_data2_i : '0;
	assign sltu_bit  = sltu_src1 < sltu_src2;

	assign and_result = unit_sel_i[SEL_AND] ? (src_data1_i & src_data2_i) : '0;
	assign or_result  = unit_sel_i[SEL_OR]  ? (src_data1_i | src_data2_i) : '0;
	assign xor_result = unit_sel_i[SEL_XOR] ? (src_data1_i ^ src_data2_i) : '0;

	assign shamt       = src_data2_i[SHAMT_WIDTH - 1 : 0];
	assign sll_src     = unit_sel_i[SEL_SLL] ? src_data1_i : '0;	// zero in gives zero out
	assign srl_src     = unit_sel_i[SEL_SRL] ? src_data1_i : '0;
	assign sra_src     = unit_sel_i[SEL_SRA] ? src_data1_i : '0;
	assign sra_shifted = $signed(sra_src) >>> shamt;

	// idle units sit at zero so a plain or merges them
	assign alu_result = adder_result | data_t'(slt_bit) | data_t'(sltu_bit) |
			    and_result | or_result | xor_result |
			    (sll_src << shamt) | (srl_src >> shamt) | data_t'(sra_shifted);

	assign alu_result_o = only_src2_used_i ? src_data2_i : alu_result;	// lui and jal bypass

	assign sub_zero  = unit_sel_i[SEL_SUB] & ~(|adder_result);	// rs1 equals rs2
	assign cond_true = (br_cond_i[COND_EQ] & sub_zero) |
			   (br_cond_i[COND_LT] & (slt_bit | sltu_bit));
	assign branch_taken_o = cond_true ^ br_cond_i[COND_INV];	// selects are 0 off branch

endmodule

// File: source/ex_result.sv
//##########################################################################
// EX to MEM pipeline register with bubble insertion
// holds under back-pressure and derives the memory address
//##########################################################################
`timescale 1ns/100ps

module ex_result
	import core_width_pkg::*;
(
	input  logic  cpu_clk,		// cpu clock
	input  logic  cpu_rstn,		// cpu reset, active low
	input  logic  dec_valid_i,	// decode holds an instruction
	input  logic  mem_ready_i,	// mem stage takes an entry
	input  data_t alu_result_i,	// result at EX
	input  rd_t   rd_i,		// destination at EX
	input  logic  load_i,
	input  logic  store_i,
	input  logic  mem_h_i,		// halfword access
	input  logic  mem_b_i,		// byte access
	input  logic  mem_u_i,		// unsigned load extension
	input  data_t store_data_i,
	output logic  ex_ready_o,	// stage can take the decode entry
	output logic  ex_valid_o,	// entry at MEM holds an instruction
	output data_t alu_result_mem_o,
	output rd_t   rd_mem_o,
	output logic  load_mem_o,
	output logic  store_mem_o,
	output logic  mem_h_mem_o,
	output logic  mem_b_mem_o,
	output logic  mem_u_mem_o,
	output data_t store_data_mem_o,
	output addr_t mem_addr_mem_o	// byte address for loads and stores
);

	assign ex_ready_o = mem_ready_i;	// nothing in EX can stall

	always_ff @(posedge cpu_clk or negedge cpu_rstn)
	begin
		if (!cpu_rstn)
		begin
			ex_valid_o       <= 1'b0;
			alu_result_mem_o <= '0;
			rd_mem_o         <= RD_NONE;
			load_mem_o       <= 1'b0;
			store_mem_o      <= 1'b0;
			mem_h_mem_o      <= 1'b0;
			mem_b_mem_o      <= 1'b0;
			mem_u_mem_o      <= 1'b0;
			store_data_mem_o <= '0;
		end
		else if (mem_ready_i)	// hold everything while mem stalls
		begin
			ex_valid_o <= dec_valid_i;
			if (!dec_valid_i)
			begin
				alu_result_mem_o <= '0;	// bubble
				rd_mem_o         <= RD_NONE;	// no writeback
				load_mem_o       <= 1'b0;
				store_mem_o      <= 1'b0;
				mem_h_mem_o      <= 1'b0;
				mem_b_mem_o      <= 1'b0;
				mem_u_mem_o      <= 1'b0;
				store_data_mem_o <= '0;
			end
			else
			begin
				alu_result_mem_o <= alu_result_i;
				rd_mem_o         <= rd_i;
				load_mem_o       <= load_i;
				store_mem_o      <= store_i;
				mem_h_mem_o      <= mem_h_i;
				mem_b_mem_o      <= mem_b_i;
				mem_u_mem_o      <= mem_u_i;
				store_data_mem_o <= store_data_i;
			end
		end
	end

	// the adder result is the effective address for memory instructions
	assign mem_addr_mem_o = (load_mem_o | store_mem_o) ? addr_t'(alu_result_mem_o) : '0;

endmodule

// File: source/ex_stage.sv
//##########################################################################
// execute stage top level
// op decode, execution units and the EX to MEM register
//##########################################################################
`timescale 1ns/100ps

module ex_stage
	import core_width_pkg::*;
	import alu_op_pkg::*;
(
	input  logic       cpu_clk,		// cpu clock
	input  logic       cpu_rstn,		// cpu reset, active low
	input  logic       dec_valid_i,	// decode holds an instruction
	output logic       ex_ready_o,		// EX takes the decode entry
	input  data_t      src_data1_i,
	input  data_t      src_data2_i,
	input  alu_op_t    alu_op_i,
	input  branch_op_t branch_op_i,
	input  logic       only_src2_used_i,	// lui and jumps
	input  rd_t        rd_i,
	input  logic       load_i,
	input  logic       store_i,
	input  logic       mem_h_i,
	input  logic       mem_b_i,
	input  logic       mem_u_i,
	input  data_t      store_data_i,
	output data_t      alu_result_ex_o,	// forwarded to decode
	output logic       branch_taken_o,
	input  logic       mem_ready_i,
	output logic       ex_valid_o,
	output data_t      alu_result_mem_o,
	output rd_t        rd_mem_o,
	output logic       load_mem_o,
	output logic       store_mem_o,
	output logic       mem_h_mem_o,
	output logic       mem_b_mem_o,
	output logic       mem_u_mem_o,
	output data_t      store_data_mem_o,
	output addr_t      mem_addr_mem_o
);

	unit_sel_t unit_sel;	// one-hot unit enables
	br_cond_t  br_cond;	// branch condition selects

	ex_decode u_decode (
		.alu_op_i    (alu_op_i),
		.branch_op_i (branch_op_i),
		.unit_sel_o  (unit_sel),
		.br_cond_o   (br_cond)
	);

	ex_execute u_execute (
		.src_data1_i      (src_data1_i),
		.src_data2_i      (src_data2_i),
		.unit_sel_i       (unit_sel),
		.br_cond_i        (br_cond),
		.only_src2_used_i (only_src2_used_i),
		.alu_result_o     (alu_result_ex_o),
		.branch_taken_o   (branch_taken_o)
	);

	ex_result u_result (
		.cpu_clk          (cpu_clk),
		.cpu_rstn         (cpu_rstn),
		.dec_valid_i      (dec_valid_i),
		.mem_ready_i      (mem_ready_i),
		.alu_result_i     (alu_result_ex_o),	// registered as seen at EX
		.rd_i             (rd_i),
		.load_i           (load_i),
		.store_i          (store_i),
		.mem_h_i          (mem_h_i),
		.mem_b_i          (mem_b_i),
		.mem_u_i          (mem_u_i),
		.store_data_i     (store_data_i),
		.ex_ready_o       (ex_ready_o),
		.ex_valid_o       (ex_valid_o),
		.alu_result_mem_o (alu_result_mem_o),
		.rd_mem_o         (rd_mem_o),
		.load_mem_o       (load_mem_o),
		.store_mem_o      (store_mem_o),
		.mem_h_mem_o      (mem_h_mem_o),
		.mem_b_mem_o      (mem_b_mem_o),
		.mem_u_mem_o      (mem_u_mem_o),
		.store_data_mem_o (store_data_mem_o),
		.mem_addr_mem_o   (mem_addr_mem_o)
	);

endmodule

// File: verification/ex_stage_tb.sv
//##########################################################################
// testbench for the execute stage
// stimulus table with expected values, reference model of the alu rules
// and the EX/MEM register, per-row checks, watchdog and summary
//##########################################################################
`timescale 1ns/100ps

module ex_stage_tb
	import core_width_pkg::*;
	import alu_op_pkg::*;
();

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 2;
	localparam int RAND_ROWS    = 40;
	localparam int RAND_SEED    = 92802;

	typedef struct packed {
		logic       dv;		// dec_valid_i
		logic       mr;		// mem_ready_i
		data_t      src1;
		data_t      src2;
		alu_op_t    aop;
		branch_op_t bop;
		logic       byp;	// only_src2_used_i
		rd_t        rd;
		logic       ld;
		logic       st;
		logic [2:0] hbu;	// mem_h, mem_b, mem_u
		data_t      sd;		// store data
		data_t      res;	// expected alu_result_ex_o
		logic       tk;		// expected branch_taken_o
	} row_t;

	logic       cpu_clk;
	logic       cpu_rstn;
	logic       dec_valid_i, mem_ready_i, only_src2_used_i;
	logic       load_i, store_i, mem_h_i, mem_b_i, mem_u_i;
	data_t      src_data1_i, src_data2_i, store_data_i;
	alu_op_t    alu_op_i;
	branch_op_t branch_op_i;
	rd_t        rd_i;
	logic       ex_ready_o, branch_taken_o, ex_valid_o;
	logic       load_mem_o, store_mem_o, mem_h_mem_o, mem_b_mem_o, mem_u_mem_o;
	data_t      alu_result_ex_o, alu_result_mem_o, store_data_mem_o;
	rd_t        rd_mem_o;
	addr_t      mem_addr_mem_o;
	row_t       rows [$];	// stimulus and expected values
	row_t       held;	// entry the EX/MEM register should show
	int         error_count;
	int         failed_tests;
	int         cur_test;
	logic       table_built;

	ex_stage UUT (.*);

	initial
	begin
		cpu_clk = 1'b0;
		forever #(CLK_PERIOD / 2) cpu_clk = ~cpu_clk;
	end

	// architectural result with each branch mapped onto its compare unit
	function automatic data_t arch_result(input data_t s1, input data_t s2, input alu_op_t op,
					      input branch_op_t bop, input logic byp);
		alu_op_t eff;
		shamt_t  sh;
		data_t   res;
		sh = s2[4:0];	// only the low 5 bits shift
		case (bop)
			BR_BEQ, BR_BNE:   eff = ALU_SUB;
			BR_BLT, BR_BGE:   eff = ALU_SLT;
			BR_BLTU, BR_BGEU: eff = ALU_SLTU;
			default:          eff = op;
		endcase
		case (eff)
			ALU_ADD:  res = s1 + s2;
			ALU_SUB:  res = s1 - s2;
			ALU_SLT:  res = data_t'($signed(s1) < $signed(s2));
			ALU_SLTU: res = data_t'(s1 < s2);
			ALU_AND:  res = s1 & s2;
			ALU_OR:   res = s1 | s2;
			ALU_XOR:  res = s1 ^ s2;
			ALU_SLL:  res = s1 << sh;
			ALU_SRL:  res = s1 >> sh;
			ALU_SRA:  res = data_t'($signed(s1) >>> sh);
			default:  res = '0;
		endcase
		if (byp)
			res = s2;	// lui and jumps
		return res;
	endfunction

	function automatic logic branch_outcome(input data_t s1, input data_t s2,
						input branch_op_t bop);
		logic tk;
		case (bop)
			BR_BEQ:  tk = (s1 == s2);
			BR_BNE:  tk = (s1 != s2);
			BR_BLT:  tk = ($signed(s1) < $signed(s2));
			BR_BGE:  tk = ($signed(s1) >= $signed(s2));
			BR_BLTU: tk = (s1 < s2);
			BR_BGEU: tk = (s1 >= s2);
			default: tk = 1'b0;	// not a branch
		endcase
		return tk;
	endfunction

	task automatic add_row(input logic dv, input logic mr, input data_t s1, input data_t s2,
			       input alu_op_t aop, input branch_op_t bop, input logic byp,
			       input rd_t rd, input logic ld, input logic st, input logic [2:0] hbu,
			       input data_t sd, input data_t res, input logic tk);
		row_t r;
		r = '{dv, mr, s1, s2, aop, bop, byp, rd, ld, st, hbu, sd, res, tk};
		rows.push_back(r);
	endtask

	// accepted alu row with a register destination and no memory access
	task automatic alu_row(input data_t s1, input data_t s2, input alu_op_t aop,
			       input data_t res);
		add_row(1, 1, s1, s2, aop, BR_NONE, 0, rd_t'(rows.size() % 32), 0, 0, 3'b000,
			s2, res, 0);
	endtask

	task automatic branch_row(input data_t s1, input data_t s2, input branch_op_t bop,
				  input data_t res, input logic tk);
		add_row(1, 1, s1, s2, ALU_NONE, bop, 0, RD_NONE, 0, 0, 3'b000, '0, res, tk);
	endtask

	task automatic add_random_rows(input int count);
		logic [31:0] ctl;
		data_t       s1;
		data_t       s2;
		alu_op_t     aop;
		branch_op_t  bop;
		for (int i = 0; i < count; i++)
		begin
			ctl = $urandom;
			s1  = $urandom;
			s2  = (ctl[3:0] == 4'd0) ? s1 : $urandom;	// some equal pairs
			aop = alu_op_t'(ctl[31:22] % 11);
			bop = ctl[4] ? branch_op_t'(ctl[31:22] % 7) : BR_NONE;
			add_row(|ctl[6:5], |ctl[8:7], s1, s2, aop, bop, &ctl[11:9], rd_t'(ctl[16:12]),
				ctl[17], ~ctl[17] & ctl[18], ctl[21:19], $urandom,
				arch_result(s1, s2, aop, bop, &ctl[11:9]), branch_outcome(s1, s2, bop));
		end
	endtask

	task automatic build_table();
		alu_row(32'h0000_0005, 32'h0000_0003, ALU_ADD,  32'h0000_0008);
		alu_row(32'hFFFF_FFFF, 32'h0000_0001, ALU_ADD,  32'h0000_0000);	// carry dropped
		alu_row(32'h0000_0010, 32'h0000_0020, ALU_SUB,  32'hFFFF_FFF0);
		alu_row(32'h0000_0007, 32'h0000_0007, ALU_SUB,  32'h0000_0000);	// zero result without a branch
		alu_row(32'h8000_0000, 32'h0000_0001, ALU_SLT,  32'h0000_0001);
		alu_row(32'h8000_0000, 32'h0000_0001, ALU_SLTU, 32'h0000_0000);
		alu_row(32'h0000_0001, 32'hFFFF_FFFF, ALU_SLT,  32'h0000_0000);
		alu_row(32'h0000_0001, 32'hFFFF_FFFF, ALU_SLTU, 32'h0000_0001);
		alu_row(32'hF0F0_1234, 32'h0FF0_FF00, ALU_AND,  32'h00F0_1200);
		alu_row(32'hF000_000F, 32'h0F00_00F0, ALU_OR,   32'hFF00_00FF);
		alu_row(32'hAAAA_5555, 32'hFFFF_0000, ALU_XOR,  32'h5555_5555);
		alu_row(32'h0000_0001, 32'h0000_0024, ALU_SLL,  32'h0000_0010);	// 36 shifts by 4
		alu_row(32'h8000_0000, 32'h0000_001F, ALU_SRL,  32'h0000_0001);
		alu_row(32'h8000_0000, 32'h0000_0004, ALU_SRA,  32'hF800_0000);	// sign fill
		alu_row(32'h7000_0000, 32'h0000_0024, ALU_SRA,  32'h0700_0000);
		alu_row(32'h1234_5678, 32'h9ABC_DEF0, ALU_NONE, 32'h0000_0000);
		add_row(1, 1, 32'h0000_1111, 32'h1234_5000, ALU_ADD, BR_NONE, 1, 6'd1, 0, 0, 3'b000,
			'0, 32'h1234_5000, 0);	// bypass as for lui
		branch_row(32'h0000_0055, 32'h0000_0055, BR_BEQ,  32'h0000_0000, 1);
		branch_row(32'h0000_0055, 32'h0000_0056, BR_BEQ,  32'hFFFF_FFFF, 0);
		branch_row(32'h0000_0055, 32'h0000_0056, BR_BNE,  32'hFFFF_FFFF, 1);
		branch_row(32'h0000_0007, 32'h0000_0007, BR_BNE,  32'h0000_0000, 0);
		branch_row(32'hFFFF_FFFE, 32'h0000_0003, BR_BLT,  32'h0000_0001, 1);	// -2 below 3
		branch_row(32'h0000_0003, 32'hFFFF_FFFE, BR_BLT,  32'h0000_0000, 0);
		branch_row(32'h0000_0005, 32'h0000_0005, BR_BLT,  32'h0000_0000, 0);
		branch_row(32'h0000_0005, 32'h0000_0005, BR_BGE,  32'h0000_0000, 1);
		branch_row(32'h8000_0000, 32'h0000_0000, BR_BGE,  32'h0000_0001, 0);
		branch_row(32'h0000_0004, 32'h0000_0003, BR_BGE,  32'h0000_0000, 1);
		branch_row(32'h0000_0003, 32'hFFFF_FFFE, BR_BLTU, 32'h0000_0001, 1);
		branch_row(32'hFFFF_FFFE, 32'h0000_0003, BR_BLTU, 32'h0000_0000, 0);
		branch_row(32'h0000_0009, 32'h0000_0009, BR_BLTU, 32'h0000_0000, 0);
		branch_row(32'hFFFF_FFFE, 32'h0000_0003, BR_BGEU, 32'h0000_0000, 1);
		branch_row(32'h0000_0009, 32'h0000_0009, BR_BGEU, 32'h0000_0000, 1);
		branch_row(32'h0000_0003, 32'h0000_0004, BR_BGEU, 32'h0000_0001, 0);
		add_row(1, 1, 32'h0000_1000, 32'h0000_0024, ALU_ADD, BR_NONE, 0, 6'd10, 1, 0, 3'b101,
			'0, 32'h0000_1024, 0);	// lhu
		add_row(1, 1, 32'h0000_2000, 32'h0000_0008, ALU_ADD, BR_NONE, 0, RD_NONE, 0, 1, 3'b010,
			32'hDEAD_BEEF, 32'h0000_2008, 0);	// sb
		add_row(1, 0, 32'h0000_0001, 32'h0000_0002, ALU_ADD, BR_NONE, 0, 6'd7, 0, 0, 3'b000,
			32'h0000_0042, 32'h0000_0003, 0);	// mem stalled so sb must stay
		add_row(0, 0, 32'h0000_0003, 32'h0000_0003, ALU_SUB, BR_NONE, 0, 6'd8, 1, 1, 3'b111,
			32'h0000_0077, 32'h0000_0000, 0);
		add_row(0, 1, 32'h0000_00F0, 32'h0000_000F, ALU_XOR, BR_NONE, 0, 6'd4, 1, 0, 3'b111,
			32'h0000_0055, 32'h0000_00FF, 0);	// bubble drops the stale fields
		add_row(1, 1, 32'h0000_00F0, 32'h0000_000F, ALU_OR, BR_NONE, 0, 6'd3, 0, 0, 3'b000,
			'0, 32'h0000_00FF, 0);
		add_random_rows(RAND_ROWS);
	endtask

	task automatic drive_inputs(input row_t r);
		dec_valid_i      <= r.dv;
		mem_ready_i      <= r.mr;
		src_data1_i      <= r.src1;
		src_data2_i      <= r.src2;
		alu_op_i         <= r.aop;
		branch_op_i      <= r.bop;
		only_src2_used_i <= r.byp;
		rd_i             <= r.rd;
		load_i           <= r.ld;
		store_i          <= r.st;
		mem_h_i          <= r.hbu[2];
		mem_b_i          <= r.hbu[1];
		mem_u_i          <= r.hbu[0];
		store_data_i     <= r.sd;
	endtask

	task automatic report_mismatch(input string name, input logic [31:0] got,
				       input logic [31:0] exp);
		$display("ERROR test %0d: %s got 0x%h expected 0x%h", cur_test, name, got, exp);
		error_count++;
	endtask

	task automatic check_registered(input row_t e);
		addr_t exp_addr;
		exp_addr = (e.ld | e.st) ? e.res : '0;	// address only for memory ops
		if (ex_valid_o !== e.dv)
			report_mismatch("ex_valid_o", 32'(ex_valid_o), 32'(e.dv));
		if (alu_result_mem_o !== e.res)
			report_mismatch("alu_result_mem_o", alu_result_mem_o, e.res);
		if (rd_mem_o !== e.rd)
			report_mismatch("rd_mem_o", 32'(rd_mem_o), 32'(e.rd));
		if (load_mem_o !== e.ld)
			report_mismatch("load_mem_o", 32'(load_mem_o), 32'(e.ld));
		if (store_mem_o !== e.st)
			report_mismatch("store_mem_o", 32'(store_mem_o), 32'(e.st));
		if (mem_h_mem_o !== e.hbu[2])
			report_mismatch("mem_h_mem_o", 32'(mem_h_mem_o), 32'(e.hbu[2]));
		if (mem_b_mem_o !== e.hbu[1])
			report_mismatch("mem_b_mem_o", 32'(mem_b_mem_o), 32'(e.hbu[1]));
		if (mem_u_mem_o !== e.hbu[0])
			report_mismatch("mem_u_mem_o", 32'(mem_u_mem_o), 32'(e.hbu[0]));
		if (store_data_mem_o !== e.sd)
			report_mismatch("store_data_mem_o", store_data_mem_o, e.sd);
		if (mem_addr_mem_o !== exp_addr)
			report_mismatch("mem_addr_mem_o", mem_addr_mem_o, exp_addr);
	endtask

	task automatic run_row(input int idx);
		row_t r;
		int   errs_before;
		r           = rows[idx];
		cur_test    = idx + 1;
		errs_before = error_count;
		@(posedge cpu_clk);
		drive_inputs(r);
		@(negedge cpu_clk);	// combinational outputs settled
		if (alu_result_ex_o !== r.res)
			report_mismatch("alu_result_ex_o", alu_result_ex_o, r.res);
		if (branch_taken_o !== r.tk)
			report_mismatch("branch_taken_o", 32'(branch_taken_o), 32'(r.tk));
		if (ex_ready_o !== r.mr)
			report_mismatch("ex_ready_o", 32'(ex_ready_o), 32'(r.mr));
		check_registered(held);	// row not taken yet
		if (r.mr)
		begin
			held = r;
			if (!r.dv)
			begin
				held    = '0;	// bubble
				held.rd = RD_NONE;
			end
		end
		@(negedge cpu_clk);	// one edge later
		check_registered(held);
		if (error_count != errs_before)
			failed_tests++;
		$display("test %0d: %s", cur_test, (error_count == errs_before) ? "ok" : "mismatch");
	endtask

	initial
	begin
		void'($urandom(RAND_SEED));
		table_built  = 1'b0;
		error_count  = 0;
		failed_tests = 0;
		cur_test     = 0;	// test 0 is the reset state
		cpu_rstn <= 1'b0;
		drive_inputs('0);
		build_table();
		table_built = 1'b1;
		repeat (RESET_CYCLES) @(posedge cpu_clk);
		cpu_rstn <= 1'b1;
		@(negedge cpu_clk);
		held    = '0;
		held.rd = RD_NONE;
		check_registered(held);
		if (ex_ready_o !== 1'b0)
			report_mismatch("ex_ready_o", 32'(ex_ready_o), 32'h0);
		if (error_count != 0)
			failed_tests++;
		$display("test 0: %s", (error_count == 0) ? "ok" : "mismatch");
		foreach (rows[i])
			run_row(i);
		$display("tests %0d, failed %0d, errors %0d", rows.size() + 1, failed_tests,
			 error_count);
		if (error_count == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// two cycles per row plus reset, bounded at four cycles per row
	initial
	begin
		wait (table_built === 1'b1);
		#((rows.size() * 4 + RESET_CYCLES + 2) * CLK_PERIOD);
		$display("timeout: the run did not reach its end in the expected time");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule
